/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := sparam_averager_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
source/sparam_pkg.sv
source/serial_divider.sv
source/wave_accumulator.sv
source/sparam_sequencer.sv
source/sparam_averager.sv
test/sparam_averager_props.sv
test/sparam_averager_tb.sv

/* source/serial_divider.sv */
`timescale 1ns/1ps

module serial_divider #(
    parameter int ACC_W = 32
) (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             start,
    input  logic [ACC_W-1:0] dividend,
    input  logic [ACC_W-1:0] divisor,
    output logic [ACC_W-1:0] quotient,
    output logic             done,
    output logic             div_zero,
    output logic             busy
);

    localparam int CNT_W = $clog2(ACC_W);

    typedef enum logic {RESTING, DIVIDING} div_state_t;

    div_state_t       state;
    logic [CNT_W-1:0] bit_cnt;
    // dividend bits shift out at the top, quotient bits shift in at the bottom
    logic [ACC_W-1:0] work;
    logic [ACC_W-1:0] rem;
    logic [ACC_W-1:0] divisor_q;
    logic             zero_q;
    // one extra bit so a large divisor cannot overflow the trial
    logic [ACC_W:0]   trial;
    logic             fits;

    assign trial = {rem, work[ACC_W-1]};
    assign fits  = (trial >= {1'b0, divisor_q});

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state    <= RESTING;
            bit_cnt  <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
            div_zero <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                RESTING: begin
                    if (start) begin
                        state    <= DIVIDING;
                        busy     <= 1'b1;
                        div_zero <= 1'b0;
                        bit_cnt  <= CNT_W'(ACC_W - 1);
                    end
                end
                DIVIDING: begin
                    bit_cnt <= bit_cnt - 1'b1;
                    // last quotient bit
                    if (bit_cnt == '0) begin
                        state    <= RESTING;
                        busy     <= 1'b0;
                        done     <= 1'b1;
                        div_zero <= zero_q;
                    end
                end
                default: state <= RESTING;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == RESTING && start) begin
            work      <= dividend;
            rem       <= '0;
            divisor_q <= divisor;
            zero_q    <= (divisor == '0);
        end else if (state == DIVIDING) begin
            work <= {work[ACC_W-2:0], fits};
            rem  <= fits ? ACC_W'(trial - {1'b0, divisor_q}) : trial[ACC_W-1:0];
            if (bit_cnt == '0) begin
                quotient <= {work[ACC_W-2:0], fits};
            end
        end
    end

endmodule

/* source/sparam_averager.sv */
`timescale 1ns/1ps

module sparam_averager #(
    parameter int ACC_W = 32
) (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  sparam_pkg::count_t      num_samples,
    input  logic                    in_valid,
    input  sparam_pkg::wave_set_t   in_data,
    output logic                    in_ready,
    output logic                    out_valid,
    output sparam_pkg::sparam_set_t out_data,
    input  logic                    out_ready
);

    logic                  frame_done;
    logic                  acc_clear;
    logic [3:0][ACC_W-1:0] phase_sum;
    logic [3:0][ACC_W-1:0] mag_sum;
    logic [7:0]            div_start;
    logic [7:0]            div_done;
    logic [7:0]            div_zero;
    logic [7:0]            div_busy;
    logic [7:0][ACC_W-1:0] div_dividend;
    logic [7:0][ACC_W-1:0] div_divisor;
    logic [7:0][ACC_W-1:0] div_quotient;

    wave_accumulator #(.ACC_W(ACC_W)) accumulator_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .enable      (in_ready),
        .clear       (acc_clear),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .num_samples (num_samples),
        .frame_done  (frame_done),
        .phase_sum   (phase_sum),
        .mag_sum     (mag_sum)
    );

    sparam_sequencer #(.ACC_W(ACC_W)) sequencer_inst (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .frame_done   (frame_done),
        .phase_sum    (phase_sum),
        .mag_sum      (mag_sum),
        .num_samples  (num_samples),
        .div_quotient (div_quotient),
        .div_done     (div_done[0]),
        .div_zero     (div_zero),
        .div_busy     (|div_busy),
        .out_ready    (out_ready),
        .acc_enable   (in_ready),
        .acc_clear    (acc_clear),
        .div_start    (div_start),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

    // eight dividers: four phases and four magnitudes, then four ratios
    for (genvar g = 0; g < 8; g++) begin : g_div
        serial_divider #(.ACC_W(ACC_W)) divider_inst (
            .clk_in   (clk_in),
            .rst_in   (rst_in),
            .start    (div_start[g]),
            .dividend (div_dividend[g]),
            .divisor  (div_divisor[g]),
            .quotient (div_quotient[g]),
            .done     (div_done[g]),
            .div_zero (div_zero[g]),
            .busy     (div_busy[g])
        );
    end

endmodule

/* source/sparam_pkg.sv */
package sparam_pkg;

    // one phase or magnitude word
    typedef logic [15:0] sample_t;

    // num_samples and the sample counter
    typedef logic [15:0] count_t;

    // phase sits in the upper half
    typedef struct packed {
        sample_t phase;
        sample_t mag;
    } wave_sample_t;

    typedef struct packed {
        wave_sample_t a1;
        wave_sample_t b1;
        wave_sample_t a2;
        wave_sample_t b2;
    } wave_set_t;

    // averaged phase difference and magnitude ratio
    typedef struct packed {
        sample_t phase;
        sample_t mag;
    } sparam_t;

    typedef struct packed {
        sparam_t s11;
        sparam_t s12;
        sparam_t s21;
        sparam_t s22;
    } sparam_set_t;

    typedef enum logic [2:0] {
        ACCUMULATE, LOAD_AVG, WAIT_AVG, LOAD_RATIO, WAIT_RATIO, SEND, HOLD
    } seq_state_t;

endpackage

/* source/sparam_sequencer.sv */
`timescale 1ns/1ps

module sparam_sequencer #(
    parameter int ACC_W = 32
) (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     frame_done,
    input  logic [3:0][ACC_W-1:0]    phase_sum,
    input  logic [3:0][ACC_W-1:0]    mag_sum,
    input  sparam_pkg::count_t       num_samples,
    input  logic [7:0][ACC_W-1:0]    div_quotient,
    input  logic                     div_done,
    input  logic [7:0]               div_zero,
    input  logic                     div_busy,
    input  logic                     out_ready,
    output logic                     acc_enable,
    output logic                     acc_clear,
    output logic [7:0]               div_start,
    output logic [7:0][ACC_W-1:0]    div_dividend,
    output logic [7:0][ACC_W-1:0]    div_divisor,
    output logic                     out_valid,
    output sparam_pkg::sparam_set_t  out_data
);

    sparam_pkg::seq_state_t    state;
    logic [3:0][ACC_W-1:0]     phase_avg;
    // averaged magnitudes, a1 b1 a2 b2
    logic [3:0][ACC_W-1:0]     mag_avg;
    sparam_pkg::sample_t [3:0] mag_ratio;
    logic [ACC_W-1:0]          samples_ext;

    assign samples_ext = ACC_W'(num_samples);
    assign acc_enable  = (state == sparam_pkg::ACCUMULATE);
    assign out_valid   = (state == sparam_pkg::HOLD);
    // sums clear on the same edge that hands off the result
    assign acc_clear   = (state == sparam_pkg::HOLD) && out_ready;

    always_comb begin
        div_start    = '0;
        div_dividend = '0;
        div_divisor  = '0;
        case (state)
            sparam_pkg::LOAD_AVG: begin
                for (int i = 0; i < 4; i++) begin
                    div_dividend[i]     = phase_sum[i];
                    div_dividend[i + 4] = mag_sum[i];
                    div_divisor[i]      = samples_ext;
                    div_divisor[i + 4]  = samples_ext;
                end
                div_start = {8{!div_busy}};
            end
            sparam_pkg::LOAD_RATIO: begin
                // b over a for s11 s12 s21 s22
                div_dividend[0] = mag_avg[1];
                div_divisor[0]  = mag_avg[0];
                div_dividend[1] = mag_avg[1];
                div_divisor[1]  = mag_avg[2];
                div_dividend[2] = mag_avg[3];
                div_divisor[2]  = mag_avg[0];
                div_dividend[3] = mag_avg[3];
                div_divisor[3]  = mag_avg[2];
                div_start[3:0]  = {4{!div_busy}};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= sparam_pkg::ACCUMULATE;
        end else begin
            case (state)
                sparam_pkg::ACCUMULATE: if (frame_done) state <= sparam_pkg::LOAD_AVG;
                sparam_pkg::LOAD_AVG:   if (!div_busy) state <= sparam_pkg::WAIT_AVG;
                sparam_pkg::WAIT_AVG:   if (div_done) state <= sparam_pkg::LOAD_RATIO;
                sparam_pkg::LOAD_RATIO: if (!div_busy) state <= sparam_pkg::WAIT_RATIO;
                sparam_pkg::WAIT_RATIO: if (div_done) state <= sparam_pkg::SEND;
                sparam_pkg::SEND:       state <= sparam_pkg::HOLD;
                sparam_pkg::HOLD:       if (out_ready) state <= sparam_pkg::ACCUMULATE;
                default:                state <= sparam_pkg::ACCUMULATE;
            endcase
        end
    end

    // dividers run in lockstep, divider 0 speaks for the bank
    always_ff @(posedge clk_in) begin
        if (state == sparam_pkg::WAIT_AVG && div_done) begin
            for (int i = 0; i < 4; i++) begin
                phase_avg[i] <= div_zero[i] ? '0 : div_quotient[i];
                mag_avg[i]   <= div_zero[i + 4] ? '0 : div_quotient[i + 4];
            end
        end
        if (state == sparam_pkg::WAIT_RATIO && div_done) begin
            for (int i = 0; i < 4; i++) begin
                // zero incident wave reports a zero ratio
                mag_ratio[i] <= div_zero[i] ? '0 : div_quotient[i][15:0];
            end
        end
        if (state == sparam_pkg::SEND) begin
            out_data.s11.phase <= phase_avg[0][15:0];
            out_data.s11.mag   <= mag_ratio[0];
            out_data.s12.phase <= phase_avg[1][15:0];
            out_data.s12.mag   <= mag_ratio[1];
            out_data.s21.phase <= phase_avg[2][15:0];
            out_data.s21.mag   <= mag_ratio[2];
            out_data.s22.phase <= phase_avg[3][15:0];
            out_data.s22.mag   <= mag_ratio[3];
        end
    end

endmodule

/* source/wave_accumulator.sv */
`timescale 1ns/1ps

module wave_accumulator #(
    parameter int ACC_W = 32
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   enable,
    input  logic                   clear,
    input  logic                   in_valid,
    input  sparam_pkg::wave_set_t  in_data,
    input  sparam_pkg::count_t     num_samples,
    output logic                   frame_done,
    output logic [3:0][ACC_W-1:0]  phase_sum,
    output logic [3:0][ACC_W-1:0]  mag_sum
);

    sparam_pkg::count_t        sample_cnt;
    sparam_pkg::sample_t [3:0] phase_diff;
    sparam_pkg::sample_t [3:0] mag_in;
    logic                      take;

    assign take = enable && in_valid;

    // high during the cycle whose edge takes the last sample
    assign frame_done = take && (sample_cnt == num_samples - 16'd1);

    // wrapping 16-bit differences, s11 s12 s21 s22
    always_comb begin
        phase_diff[0] = in_data.b1.phase - in_data.a1.phase;
        phase_diff[1] = in_data.b1.phase - in_data.a2.phase;
        phase_diff[2] = in_data.b2.phase - in_data.a1.phase;
        phase_diff[3] = in_data.b2.phase - in_data.a2.phase;
    end

    // magnitudes in a1 b1 a2 b2 order
    always_comb begin
        mag_in[0] = in_data.a1.mag;
        mag_in[1] = in_data.b1.mag;
        mag_in[2] = in_data.a2.mag;
        mag_in[3] = in_data.b2.mag;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in || clear) begin
            sample_cnt <= '0;
            phase_sum  <= '0;
            mag_sum    <= '0;
        end else if (take) begin
            sample_cnt <= sample_cnt + 16'd1;
            for (int i = 0; i < 4; i++) begin
                phase_sum[i] <= phase_sum[i] + ACC_W'(phase_diff[i]);
                mag_sum[i]   <= mag_sum[i] + ACC_W'(mag_in[i]);
            end
        end
    end

endmodule

/* test/sparam_averager_props.sv */
`timescale 1ns/1ps

module sparam_averager_props (
    input logic                    clk_in,
    input logic                    rst_in,
    input sparam_pkg::count_t      num_samples,
    input logic                    in_valid,
    input logic                    in_ready,
    input logic                    out_valid,
    input sparam_pkg::sparam_set_t out_data,
    input logic                    out_ready
);

    // a result and new samples are never offered together
    no_overlap: assert property (@(posedge clk_in) disable iff (rst_in)
        !(out_valid && in_ready))
        else $error("out_valid and in_ready are high together");

    // stalled result keeps its value
    result_held: assert property (@(posedge clk_in) disable iff (rst_in)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("result changed or dropped while out_ready was low");

    count_nonzero: assert property (@(posedge clk_in) disable iff (rst_in)
        in_valid |-> (num_samples != '0))
        else $error("num_samples is zero while in_valid is high");

endmodule

bind sparam_averager sparam_averager_props props_inst (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .num_samples (num_samples),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_ready   (out_ready)
);

/* test/sparam_averager_tb.sv */
`timescale 1ns/1ps

module sparam_averager_tb;

    localparam int MAX_SAMPLES = 16;
    localparam int NUM_FRAMES  = 8;
    // two divider passes of 33 cycles plus sequencer overhead
    localparam int RESULT_WAIT = 2 * 33 + 20;
    localparam int HOLD_CYCLES = 20;
    localparam int WATCHDOG    = 2 * NUM_FRAMES * (MAX_SAMPLES + RESULT_WAIT + HOLD_CYCLES) + 20;

    logic                    clk_in = 1'b0;
    logic                    rst_in;
    sparam_pkg::count_t      num_samples;
    logic                    in_valid;
    sparam_pkg::wave_set_t   in_data;
    logic                    in_ready;
    logic                    out_valid;
    sparam_pkg::sparam_set_t out_data;
    logic                    out_ready;

    sparam_pkg::wave_set_t frame [MAX_SAMPLES];
    int errors = 0;
    int passed = 0;
    int failed = 0;

    sparam_averager #(.ACC_W(32)) sparam_averager_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .num_samples (num_samples),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready)
    );

    always #50 clk_in = ~clk_in;

    initial begin
        repeat (WATCHDOG) @(posedge clk_in);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // b over a or zero when a is zero
    function automatic logic [15:0] ratio(input longint b, input longint a);
        if (a == 0) begin
            return '0;
        end
        return 16'(b / a);
    endfunction

    // expected result set over the first n entries of frame
    function automatic sparam_pkg::sparam_set_t model(input int n);
        longint                  ph [4];
        longint                  mg [4];
        logic [15:0]             d [4];
        sparam_pkg::sparam_set_t r;
        for (int k = 0; k < 4; k++) begin
            ph[k] = 0;
            mg[k] = 0;
        end
        for (int i = 0; i < n; i++) begin
            d[0] = frame[i].b1.phase - frame[i].a1.phase;
            d[1] = frame[i].b1.phase - frame[i].a2.phase;
            d[2] = frame[i].b2.phase - frame[i].a1.phase;
            d[3] = frame[i].b2.phase - frame[i].a2.phase;
            for (int k = 0; k < 4; k++) begin
                ph[k] += d[k];
            end
            mg[0] += frame[i].a1.mag;
            mg[1] += frame[i].b1.mag;
            mg[2] += frame[i].a2.mag;
            mg[3] += frame[i].b2.mag;
        end
        for (int k = 0; k < 4; k++) begin
            ph[k] = ph[k] / n;
            mg[k] = mg[k] / n;
        end
        r.s11 = {16'(ph[0]), ratio(mg[1], mg[0])};
        r.s12 = {16'(ph[1]), ratio(mg[1], mg[2])};
        r.s21 = {16'(ph[2]), ratio(mg[3], mg[0])};
        r.s22 = {16'(ph[3]), ratio(mg[3], mg[2])};
        return r;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_set(input string what, input sparam_pkg::sparam_set_t exp);
        check({what, " s11"}, out_data.s11, exp.s11);
        check({what, " s12"}, out_data.s12, exp.s12);
        check({what, " s21"}, out_data.s21, exp.s21);
        check({what, " s22"}, out_data.s22, exp.s22);
    endtask

    // a1 magnitudes stay nonzero unless a test clears them
    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++) begin
            frame[i].a1 = {16'($urandom), 16'($urandom_range(4095, 1))};
            frame[i].b1 = {16'($urandom), 16'($urandom)};
            frame[i].a2 = {16'($urandom), 16'($urandom_range(4095, 1))};
            frame[i].b2 = {16'($urandom), 16'($urandom)};
        end
    endtask

    // in_ready only moves on a rising edge and is read in the low phase
    task automatic drive_frame(input int n);
        int i;
        i = 0;
        while (i < n) begin
            @(negedge clk_in);
            in_valid = 1'b1;
            in_data  = frame[i];
            if (in_ready) begin
                i++;
            end
        end
        @(negedge clk_in);
        in_valid = 1'b0;
    endtask

    task automatic wait_result(output bit seen);
        int cycles;
        cycles = 0;
        while (!out_valid && cycles < RESULT_WAIT) begin
            @(negedge clk_in);
            cycles++;
        end
        seen = out_valid;
        if (!seen) begin
            $display("no result within %0d cycles after the last sample", RESULT_WAIT);
            errors++;
        end
    endtask

    task automatic accept_result();
        out_ready = 1'b1;
        @(negedge clk_in);
        out_ready = 1'b0;
        check("in_ready after accept", 32'(in_ready), 32'd1);
        check("out_valid after accept", 32'(out_valid), 32'd0);
    endtask

    task automatic run_frame(input string what, input int n);
        sparam_pkg::sparam_set_t exp;
        bit                      seen;
        exp = model(n);
        @(negedge clk_in);
        num_samples = 16'(n);
        drive_frame(n);
        wait_result(seen);
        if (seen) begin
            check_set(what, exp);
            accept_result();
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_single_sample();
        int e;
        e = errors;
        frame[0].a1 = {16'h1000, 16'd100};
        frame[0].b1 = {16'h3000, 16'd450};
        frame[0].a2 = {16'h0800, 16'd30};
        frame[0].b2 = {16'h5000, 16'd900};
        run_frame("single", 1);
        finish_test("single_sample", e);
    endtask

    task automatic test_averaging();
        int e;
        e = errors;
        fill_random(8);
        run_frame("average", 8);
        finish_test("averaging", e);
    endtask

    // b phases below a phases so every difference wraps
    task automatic test_phase_wrap();
        int e;
        e = errors;
        fill_random(8);
        for (int i = 0; i < 8; i++) begin
            frame[i].a1.phase = 16'($urandom_range(65535, 32768));
            frame[i].a2.phase = 16'($urandom_range(65535, 32768));
            frame[i].b1.phase = 16'($urandom_range(32767, 0));
            frame[i].b2.phase = 16'($urandom_range(32767, 0));
        end
        run_frame("wrap", 8);
        finish_test("phase_wrap", e);
    endtask

    task automatic test_zero_incident();
        int e;
        e = errors;
        fill_random(5);
        for (int i = 0; i < 5; i++) begin
            frame[i].a1.mag = '0;
        end
        run_frame("zero a1", 5);
        finish_test("zero_incident", e);
    endtask

    task automatic test_back_pressure();
        sparam_pkg::sparam_set_t exp;
        bit                      seen;
        int                      e;
        e = errors;
        fill_random(6);
        exp = model(6);
        @(negedge clk_in);
        num_samples = 16'd6;
        drive_frame(6);
        wait_result(seen);
        if (seen) begin
            check_set("stalled", exp);
            // samples offered during the stall must not be counted
            repeat (HOLD_CYCLES) begin
                in_valid = 1'b1;
                in_data  = {$urandom, $urandom, $urandom, $urandom};
                @(negedge clk_in);
                check("out_valid during stall", 32'(out_valid), 32'd1);
                check("in_ready during stall", 32'(in_ready), 32'd0);
                check_set("held", exp);
            end
            in_valid = 1'b0;
            accept_result();
        end
        fill_random(6);
        run_frame("after stall", 6);
        finish_test("back_pressure", e);
    endtask

    task automatic test_back_to_back();
        int e;
        e = errors;
        fill_random(4);
        run_frame("first", 4);
        fill_random(4);
        run_frame("second", 4);
        finish_test("back_to_back", e);
    endtask

    initial begin
        void'($urandom(9465));
        rst_in      = 1'b1;
        num_samples = 16'd1;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        repeat (5) @(negedge clk_in);
        rst_in = 1'b0;
        check("in_ready after reset", 32'(in_ready), 32'd1);
        check("out_valid after reset", 32'(out_valid), 32'd0);

        test_single_sample();
        test_averaging();
        test_phase_wrap();
        test_zero_incident();
        test_back_pressure();
        test_back_to_back();

        $display("tests passed: %0d, failed: %0d, check errors: %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
